// File: logic/logWriter_cfg.svh
`ifndef LOGWRITER_CFG_SVH
`define LOGWRITER_CFG_SVH

// sector geometry
`define SECTOR_BYTES 512
`define SECTOR_INDEX_W 9

// input buffer, two sectors deep
`define FIFO_DEPTH 1024

// directory scan
`define DIR_SEARCH_LIMIT 4
`define FILE_NAME "LOGDATA BIN"

// largest partition base accepted from the MBR
`define MBR_BASE_MAX 65536

// --------------------------------------------------
// byte offsets inside MBR, boot sector, dir entry
// --------------------------------------------------
`define MBR_PART_OFS 454
`define BPB_SPC_OFS 13
`define BPB_RSVD_OFS 14
`define BPB_NFAT_OFS 16
`define BPB_FATSZ_OFS 36
`define BPB_ROOTCLUS_OFS 44
`define ENTRY_CLUS_HI_OFS 20
`define ENTRY_CLUS_LO_OFS 26
`define ENTRY_SIZE_OFS 28

`endif

// File: logic/logWriterPkg.sv
`include "logWriter_cfg.svh"

package logWriterPkg;

  // card side sector number
  typedef logic [31:0] sectorAddrT;

  // one data byte
  typedef logic [7:0] byteT;

  // position inside a sector
  typedef logic [`SECTOR_INDEX_W-1:0] byteIndexT;

  // fill level, one bit wider than the pointers
  typedef logic [$clog2(`FIFO_DEPTH):0] fifoCountT;

  // FAT32 cluster number
  typedef logic [31:0] clusterT;

  // sequencer states, codes show on the status port
  typedef enum logic [3:0] {
    idle      = 4'd0,
    readMbr   = 4'd1,
    checkMbr  = 4'd2,
    readBoot  = 4'd3,
    checkBoot = 4'd4,
    readDir   = 4'd5,
    checkDir  = 4'd6,
    waitData  = 4'd8,
    writeData = 4'd9,
    writeDir  = 4'd11,
    fault     = 4'd15
  } seqStateT;

endpackage

// File: logic/sectorStreamIf.sv
`timescale 1ns/1ps

interface sectorStreamIf;

  // one pulse per byte moved on the card port
  logic                    byteStrobe;
  logWriterPkg::byteIndexT byteIndex;
  logWriterPkg::byteT      byteData;
  // strobe of byte 511
  logic                    lastByte;
  // end of transfer, rearms the counter
  logic                    clear;

  modport counter (
    output byteStrobe, byteIndex, byteData, lastByte,
    input  clear
  );

  modport sequencer (
    output clear,
    input  lastByte
  );

  modport sink (
    input byteStrobe, byteIndex, byteData, lastByte
  );

endinterface

// File: logic/sectorSequencer.sv
`timescale 1ns/1ps
`include "logWriter_cfg.svh"

module sectorSequencer (
  input  logic                     clk,
  input  logic                     rstn,
  sectorStreamIf.sequencer         stream,
  output logic                     secRdReq,
  input  logic                     secRdAck,
  output logic                     secWrReq,
  input  logic                     secWrAck,
  output logWriterPkg::sectorAddrT secAddr,
  input  logic                     mbrValid,
  input  logic                     bootValid,
  input  logWriterPkg::sectorAddrT partBase,
  input  logWriterPkg::sectorAddrT dirSector,
  input  logWriterPkg::sectorAddrT dataStart,
  input  logWriterPkg::byteT       sectorsPerCluster,
  input  logic                     nameFound,
  input  logWriterPkg::clusterT    fileCluster,
  input  logWriterPkg::fifoCountT  fifoCount,
  input  logWriterPkg::byteT       fifoByte,
  input  logWriterPkg::byteT       dirByte,
  output logWriterPkg::byteT       secWrByte,
  output logWriterPkg::sectorAddrT fileSectors,
  output logWriterPkg::seqStateT   status
);

  logWriterPkg::seqStateT   state;
  logWriterPkg::sectorAddrT fileStart, dirAddr;
  logic [2:0]               dirCount;
  logic                     rdPhase, wrPhase, rdDone, wrDone, sawLast;

  assign status  = state;
  assign rdPhase = state inside {logWriterPkg::readMbr, logWriterPkg::readBoot,
                                 logWriterPkg::readDir};
  assign wrPhase = state inside {logWriterPkg::writeData, logWriterPkg::writeDir};
  assign rdDone  = secRdReq && secRdAck;
  assign wrDone  = secWrReq && secWrAck;

  // data sectors from the FIFO and the dir sector from the store
  assign secWrByte = (state == logWriterPkg::writeData) ? fifoByte : dirByte;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= logWriterPkg::idle;
      secRdReq     <= 1'b0;
      secWrReq     <= 1'b0;
      stream.clear <= 1'b0;
      secAddr      <= '0;
      fileSectors  <= '0;
      dirCount     <= '0;
    end else begin
      stream.clear <= rdDone || wrDone;
      // --------------------------------------------------
      // requests rise only once the old ack is gone
      // --------------------------------------------------
      if (rdDone) secRdReq <= 1'b0;
      else if (rdPhase && !secRdReq && !secRdAck) secRdReq <= 1'b1;
      if (wrDone) secWrReq <= 1'b0;
      else if (wrPhase && !secWrReq && !secWrAck) secWrReq <= 1'b1;

      case (state)
        logWriterPkg::idle: begin
          secAddr <= '0;
          state   <= logWriterPkg::readMbr;
        end
        logWriterPkg::readMbr:  if (rdDone) state <= logWriterPkg::checkMbr;
        logWriterPkg::checkMbr: begin
          secAddr <= partBase;
          state   <= mbrValid ? logWriterPkg::readBoot : logWriterPkg::fault;
        end
        logWriterPkg::readBoot: if (rdDone) state <= logWriterPkg::checkBoot;
        logWriterPkg::checkBoot: begin
          secAddr  <= dirSector;
          dirAddr  <= dirSector;
          dirCount <= '0;
          state    <= bootValid ? logWriterPkg::readDir : logWriterPkg::fault;
        end
        logWriterPkg::readDir:  if (rdDone) state <= logWriterPkg::checkDir;
        logWriterPkg::checkDir: begin
          if (nameFound) begin
            // first sector of the start cluster
            fileStart   <= dataStart + (fileCluster - 32'd2) * sectorsPerCluster;
            fileSectors <= '0;
            state       <= logWriterPkg::waitData;
          end else if (dirCount == 3'(`DIR_SEARCH_LIMIT - 1)) begin
            state <= logWriterPkg::fault;
          end else begin
            dirAddr  <= dirAddr + 32'd1;
            secAddr  <= dirAddr + 32'd1;
            dirCount <= dirCount + 3'd1;
            state    <= logWriterPkg::readDir;
          end
        end
        logWriterPkg::waitData: begin
          if (fifoCount >= `SECTOR_BYTES) begin
            secAddr <= fileStart + fileSectors;
            state   <= logWriterPkg::writeData;
          end
        end
        logWriterPkg::writeData: begin
          if (wrDone) begin
            // size patch must see the new count
            fileSectors <= fileSectors + 32'd1;
            secAddr     <= dirAddr;
            state       <= logWriterPkg::writeDir;
          end
        end
        logWriterPkg::writeDir: if (wrDone) state <= logWriterPkg::waitData;
        default: state <= logWriterPkg::fault;
      endcase
    end
  end

  // byte 511 seen in the current transfer
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) sawLast <= 1'b0;
    else if (stream.clear) sawLast <= 1'b0;
    else if (stream.lastByte) sawLast <= 1'b1;
  end

  // request and its sector number hold until the ack
  assert property (@(posedge clk) disable iff (!rstn)
                   secRdReq && !secRdAck |=> secRdReq && $stable(secAddr))
    else $error("read request or address dropped before ack");
  assert property (@(posedge clk) disable iff (!rstn)
                   secWrReq && !secWrAck |=> secWrReq && $stable(secAddr))
    else $error("write request or address dropped before ack");
  // card acks only a full sector
  assert property (@(posedge clk) disable iff (!rstn) (rdDone || wrDone) |-> sawLast)
    else $error("sector ack before byte 511");

endmodule

// File: logic/sectorByteCounter.sv
`timescale 1ns/1ps
`include "logWriter_cfg.svh"

module sectorByteCounter (
  input  logic               clk,
  input  logic               rstn,
  input  logic               secRdValid,
  input  logWriterPkg::byteT secRdByte,
  input  logic               secWrTake,
  sectorStreamIf.counter     stream
);

  logWriterPkg::byteIndexT count;
  // set after byte 511 until the sequencer clears
  logic                    sectorDone;

  // same cycle as the valid or take
  assign stream.byteStrobe = secRdValid || secWrTake;
  assign stream.byteIndex  = count;
  assign stream.byteData   = secRdByte;
  assign stream.lastByte   = stream.byteStrobe &&
                             (count == logWriterPkg::byteIndexT'(`SECTOR_BYTES - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      count      <= '0;
      sectorDone <= 1'b0;
    end else if (stream.clear) begin
      count      <= '0;
      sectorDone <= 1'b0;
    end else if (stream.byteStrobe) begin
      // wraps to 0 after byte 511
      count <= count + 1'b1;
      if (stream.lastByte) sectorDone <= 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rstn) stream.byteStrobe |-> !sectorDone)
    else $error("byte strobe past end of sector");

endmodule

// File: logic/bootParser.sv
`timescale 1ns/1ps
`include "logWriter_cfg.svh"

module bootParser (
  input  logic                     clk,
  input  logic                     rstn,
  sectorStreamIf.sink              stream,
  input  logWriterPkg::seqStateT   phase,
  output logWriterPkg::sectorAddrT partBase,
  output logWriterPkg::sectorAddrT dataStart,
  output logWriterPkg::sectorAddrT dirSector,
  output logWriterPkg::byteT       sectorsPerCluster,
  output logic                     mbrValid,
  output logic                     bootValid
);

  logWriterPkg::byteT       sig0, sig1, numFats;
  logic [15:0]              rsvdSectors;
  logWriterPkg::sectorAddrT fatSize;
  logWriterPkg::clusterT    rootCluster;
  logWriterPkg::byteIndexT  idx;
  logic                     mbrByte, bootByte;

  function automatic logic inField(input logWriterPkg::byteIndexT i, input int ofs,
                                   input int len);
    return (int'(i) >= ofs) && (int'(i) < ofs + len);
  endfunction

  // byte lane of a little-endian field
  function automatic logic [1:0] lane(input logWriterPkg::byteIndexT i, input int ofs);
    return 2'(int'(i) - ofs);
  endfunction

  assign idx      = stream.byteIndex;
  assign mbrByte  = stream.byteStrobe && (phase == logWriterPkg::readMbr);
  assign bootByte = stream.byteStrobe && (phase == logWriterPkg::readBoot);

  // fields that decide validity
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sig0              <= '0;
      sig1              <= '0;
      sectorsPerCluster <= '0;
      rsvdSectors       <= '0;
    end else begin
      if (mbrByte && idx == 9'd510) sig0 <= stream.byteData;
      if (mbrByte && idx == 9'd511) sig1 <= stream.byteData;
      if (bootByte && idx == 9'(`BPB_SPC_OFS)) sectorsPerCluster <= stream.byteData;
      if (bootByte && inField(idx, `BPB_RSVD_OFS, 2))
        rsvdSectors[8*lane(idx, `BPB_RSVD_OFS) +: 8] <= stream.byteData;
    end
  end

  // geometry fields
  always_ff @(posedge clk) begin
    if (mbrByte && inField(idx, `MBR_PART_OFS, 4))
      partBase[8*lane(idx, `MBR_PART_OFS) +: 8] <= stream.byteData;
    if (bootByte && idx == 9'(`BPB_NFAT_OFS)) numFats <= stream.byteData;
    if (bootByte && inField(idx, `BPB_FATSZ_OFS, 4))
      fatSize[8*lane(idx, `BPB_FATSZ_OFS) +: 8] <= stream.byteData;
    if (bootByte && inField(idx, `BPB_ROOTCLUS_OFS, 4))
      rootCluster[8*lane(idx, `BPB_ROOTCLUS_OFS) +: 8] <= stream.byteData;
  end

  assign mbrValid  = (sig0 == 8'h55) && (sig1 == 8'hAA) && (partBase != '0) &&
                     (partBase <= `MBR_BASE_MAX);
  assign bootValid = (sectorsPerCluster != '0) && (rsvdSectors != '0);

  // data area follows the FATs, root dir sits at its cluster
  assign dataStart = partBase + rsvdSectors + numFats * fatSize;
  assign dirSector = dataStart + (rootCluster - 32'd2) * sectorsPerCluster;

endmodule

// File: logic/dirSectorStore.sv
`timescale 1ns/1ps
`include "logWriter_cfg.svh"

module dirSectorStore (
  input  logic                     clk,
  input  logic                     rstn,
  sectorStreamIf.sink              stream,
  input  logic                     loading,
  input  logWriterPkg::sectorAddrT fileSectors,
  output logic                     nameFound,
  output logWriterPkg::clusterT    fileCluster,
  output logWriterPkg::byteT       dirByte
);

  localparam logic [87:0] FileName = `FILE_NAME;

  logWriterPkg::byteT       ram [`SECTOR_BYTES];
  logWriterPkg::byteIndexT  idx;
  logWriterPkg::sectorAddrT fileBytes;
  logic [4:0]               entryByte;
  logic [3:0]               slot, entrySlot;
  logic                     nameMatch, loadByte;

  // k-th character of the 8.3 name
  function automatic logWriterPkg::byteT nameChar(input logic [4:0] k);
    return FileName[8*(10-k) +: 8];
  endfunction

  assign idx       = stream.byteIndex;
  assign entryByte = idx[4:0];
  assign slot      = idx[8:5];
  assign loadByte  = loading && stream.byteStrobe;

  always_ff @(posedge clk) begin
    if (loadByte) ram[idx] <= stream.byteData;
  end

  // --------------------------------------------------
  // name compare, one 32 byte entry at a time
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      nameFound <= 1'b0;
      nameMatch <= 1'b0;
      entrySlot <= '0;
    end else if (loadByte) begin
      if (entryByte == 5'd0)
        nameMatch <= (stream.byteData == nameChar(5'd0));
      else if (entryByte < 5'd11)
        nameMatch <= nameMatch && (stream.byteData == nameChar(entryByte));
      // new sector, forget the last search
      if (idx == '0) begin
        nameFound <= 1'b0;
      end else if (entryByte == 5'd10 && !nameFound && nameMatch &&
                   stream.byteData == nameChar(5'd10)) begin
        nameFound <= 1'b1;
        entrySlot <= slot;
      end
    end
  end

  // start cluster words come after the name
  always_ff @(posedge clk) begin
    if (loadByte && nameFound && slot == entrySlot) begin
      case (entryByte)
        5'(`ENTRY_CLUS_HI_OFS):     fileCluster[23:16] <= stream.byteData;
        5'(`ENTRY_CLUS_HI_OFS + 1): fileCluster[31:24] <= stream.byteData;
        5'(`ENTRY_CLUS_LO_OFS):     fileCluster[7:0]   <= stream.byteData;
        5'(`ENTRY_CLUS_LO_OFS + 1): fileCluster[15:8]  <= stream.byteData;
        default: ;
      endcase
    end
  end

  // size in bytes, whole sectors only
  assign fileBytes = fileSectors << $clog2(`SECTOR_BYTES);

  // readout follows the write take index
  always_comb begin
    dirByte = ram[idx];
    if (slot == entrySlot && entryByte >= 5'(`ENTRY_SIZE_OFS))
      dirByte = fileBytes[8*idx[1:0] +: 8];
  end

endmodule

// File: logic/sectorFifo.sv
`timescale 1ns/1ps
`include "logWriter_cfg.svh"

module sectorFifo (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    inReq,
  input  logWriterPkg::byteT      inByte,
  output logic                    inAck,
  input  logic                    secWrTake,
  input  logic                    writing,
  output logWriterPkg::byteT      fifoByte,
  output logWriterPkg::fifoCountT fifoCount
);

  localparam int PtrW = $clog2(`FIFO_DEPTH);

  logWriterPkg::byteT mem [`FIFO_DEPTH];
  logic [PtrW-1:0]    wrPtr, rdPtr;
  logic               push, pop;

  // accept once per req, held off while full
  assign push     = inReq && !inAck && (fifoCount != `FIFO_DEPTH);
  assign pop      = secWrTake && writing;
  // head byte, no read latency
  assign fifoByte = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= inByte;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      inAck     <= 1'b0;
      fifoCount <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
        inAck <= 1'b1;
      end else if (!inReq) begin
        inAck <= 1'b0;
      end
      if (pop) rdPtr <= rdPtr + 1'b1;
      fifoCount <= fifoCount + logWriterPkg::fifoCountT'(push)
                             - logWriterPkg::fifoCountT'(pop);
    end
  end

  // card takes only what the sequencer saw buffered
  assert property (@(posedge clk) disable iff (!rstn)
                   !(pop && fifoCount == '0) && fifoCount <= `FIFO_DEPTH)
    else $error("FIFO underflow or overflow");

endmodule

// File: logic/logWriterTop.sv
`timescale 1ns/1ps

module logWriterTop (
  input  logic                     clk,
  input  logic                     rstn,
  // byte source, four-phase
  input  logic                     inReq,
  input  logWriterPkg::byteT       inByte,
  output logic                     inAck,
  // card sector port
  output logWriterPkg::sectorAddrT secAddr,
  output logic                     secRdReq,
  input  logic                     secRdAck,
  input  logic                     secRdValid,
  input  logWriterPkg::byteT       secRdByte,
  output logic                     secWrReq,
  input  logic                     secWrAck,
  input  logic                     secWrTake,
  output logWriterPkg::byteT       secWrByte,
  output logWriterPkg::seqStateT   status
);

  sectorStreamIf stream ();

  logic                     mbrValid, bootValid, nameFound;
  logic                     dirLoading, fifoWriting;
  logWriterPkg::sectorAddrT partBase, dataStart, dirSector, fileSectors;
  logWriterPkg::byteT       sectorsPerCluster, fifoByte, dirByte;
  logWriterPkg::clusterT    fileCluster;
  logWriterPkg::fifoCountT  fifoCount;

  // state decode for the data blocks
  assign dirLoading  = (status == logWriterPkg::readDir);
  assign fifoWriting = (status == logWriterPkg::writeData);

  sectorSequencer u_seq (
    .clk, .rstn,
    .stream            (stream.sequencer),
    .secRdReq, .secRdAck, .secWrReq, .secWrAck, .secAddr,
    .mbrValid, .bootValid, .partBase, .dirSector, .dataStart, .sectorsPerCluster,
    .nameFound, .fileCluster,
    .fifoCount, .fifoByte, .dirByte,
    .secWrByte, .fileSectors, .status
  );

  sectorByteCounter u_cnt (
    .clk, .rstn, .secRdValid, .secRdByte, .secWrTake,
    .stream (stream.counter)
  );

  bootParser u_boot (
    .clk, .rstn,
    .stream (stream.sink),
    .phase  (status),
    .partBase, .dataStart, .dirSector, .sectorsPerCluster, .mbrValid, .bootValid
  );

  dirSectorStore u_dir (
    .clk, .rstn,
    .stream  (stream.sink),
    .loading (dirLoading),
    .fileSectors, .nameFound, .fileCluster, .dirByte
  );

  sectorFifo u_fifo (
    .clk, .rstn, .inReq, .inByte, .inAck, .secWrTake,
    .writing (fifoWriting),
    .fifoByte, .fifoCount
  );

endmodule

// File: tests/logWriterChecker.sv
`timescale 1ns/1ps

module logWriterChecker #(
  parameter int EntryOfs = 96
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     inReq,
  input  logWriterPkg::byteT       inByte,
  input  logic                     inAck,
  input  logWriterPkg::sectorAddrT secAddr,
  input  logic                     secRdReq,
  input  logic                     secRdAck,
  input  logic                     secRdValid,
  input  logWriterPkg::byteT       secRdByte,
  input  logic                     secWrReq,
  input  logic                     secWrAck,
  input  logic                     secWrTake,
  input  logWriterPkg::byteT       secWrByte,
  input  logic [3:0]               status,
  input  logic [127:0]             testName,
  input  logic                     rowDone,
  input  int                       expSectors,
  input  logic [3:0]               expStatus,
  input  logic                     expFull,
  output int                       errorCount
);

  // card geometry: root dir = 2048 + 32 + 2 * 100, file at cluster 5
  localparam int BootAddr  = 2048;
  localparam int RootAddr  = 2048 + 32 + 2 * 100;
  localparam int EntryAddr = RootAddr + 1;
  localparam int FileAddr  = RootAddr + (5 - 2) * 8;

  logWriterPkg::byteT inQ [$];
  logWriterPkg::byteT dirImage [512];
  logic               rdReqQ, wrReqQ, inAckQ, rdAckQ, wrAckQ, curData;
  int                 rdCount, wrCount, takeIdx, rdIdx, pending, fullSeen, curRdAddr;

  function automatic int expReadAddr(input int n);
    case (n)
      0: return 0;
      1: return BootAddr;
      2: return RootAddr;
      default: return EntryAddr;
    endcase
  endfunction

  task automatic checkValue(input string what, input longint expv, input longint actv);
    if (expv != actv) begin
      errorCount++;
      $display("** Error [%0s] %s: expected %0h, actual %0h", testName, what, expv, actv);
    end
  endtask

  task automatic failNote(input string what);
    errorCount++;
    $display("[%0s] %s", testName, what);
  endtask

  initial errorCount = 0;

  always @(posedge clk) begin
    int expB;
    int ofs;
    logWriterPkg::byteT got;
    if (!rstn) begin
      inQ.delete();
      {rdReqQ, wrReqQ, inAckQ, rdAckQ, wrAckQ, curData} = '0;
      {rdCount, wrCount, takeIdx, rdIdx, pending, fullSeen, curRdAddr} = '0;
      if (status != 4'd0 || secRdReq || secWrReq || inAck)
        failNote("outputs not idle during reset");
    end else begin
      // --------------------------------------------------
      // input side
      // --------------------------------------------------
      if (inAck && !inAckQ) begin
        if (pending >= 1024) failNote("byte accepted while FIFO full");
        inQ.push_back(inByte);
        pending++;
      end
      if (inReq && !inAck && pending >= 1024) fullSeen++;
      // reads
      if (secRdReq && !rdReqQ) begin
        if (rdCount > 3) failNote("read request beyond the directory search");
        checkValue("read address", expReadAddr(rdCount), secAddr);
        curRdAddr = secAddr;
        rdIdx = 0;
      end
      if (secRdValid && secRdReq) begin
        if (curRdAddr == EntryAddr && rdIdx < 512) dirImage[rdIdx] = secRdByte;
        rdIdx++;
      end
      if (secRdAck && !rdAckQ) rdCount++;
      // --------------------------------------------------
      // writes: data sector then directory sector
      // --------------------------------------------------
      if (secWrReq && !wrReqQ) begin
        curData = (wrCount % 2 == 0);
        checkValue("write address", curData ? FileAddr + wrCount / 2 : EntryAddr, secAddr);
        takeIdx = 0;
      end
      if (secWrReq && secWrTake) begin
        got = secWrByte;
        if (curData) begin
          if (inQ.size() == 0) begin
            failNote("data byte written that was never sent");
          end else begin
            checkValue("data byte", inQ.pop_front(), got);
          end
          pending--;
        end else begin
          ofs  = takeIdx - EntryOfs - 28;
          expB = (takeIdx < 512) ? dirImage[takeIdx] : 0;
          // size field in bytes, little-endian
          if (ofs >= 0 && ofs < 4) expB = ((((wrCount + 1) / 2) * 512) >> (8 * ofs)) & 8'hFF;
          checkValue("directory byte", expB, got);
        end
        takeIdx++;
      end
      if (secWrAck && !wrAckQ) begin
        checkValue("takes per sector", 512, takeIdx);
        wrCount++;
      end
      // end of row summary
      if (rowDone) begin
        checkValue("final status", expStatus, status);
        checkValue("sector writes", 2 * expSectors, wrCount);
        checkValue("sector reads", (expStatus == 4'd15) ? 1 : 4, rdCount);
        if (expStatus != 4'd15 && inQ.size() != 0) failNote("input bytes never written");
        if (expFull && fullSeen == 0) failNote("FIFO never applied back-pressure");
      end
      rdReqQ = secRdReq;
      wrReqQ = secWrReq;
      inAckQ = inAck;
      rdAckQ = secRdAck;
      wrAckQ = secWrAck;
    end
  end

endmodule

// File: tests/logWriterTb.sv
`timescale 1ns/1ps

module logWriterTb;

  localparam int Rows     = 3;
  localparam int EntryOfs = 96;
  localparam logic [87:0] FileName = "LOGDATA BIN";

  logic clk, rstn, inReq, inAck, secRdReq, secRdAck, secRdValid;
  logic secWrReq, secWrAck, secWrTake, rowDone, badMbr, expFull;
  logWriterPkg::byteT       inByte, secRdByte, secWrByte;
  logWriterPkg::sectorAddrT secAddr;
  logWriterPkg::seqStateT   status;
  logic [127:0]             testName;
  logic [3:0]               expStatus;
  int                       expSectors, errorCount, writesDone, cycles, limit;

  // stimulus table
  logic [127:0] rowName [Rows];
  int           rowBytes [Rows];
  logic         rowBadMbr [Rows];
  int           rowSectors [Rows];
  logic [3:0]   rowStatus [Rows];
  logic         rowFull [Rows];

  logWriterTop u_dut (.*);

  logWriterChecker #(.EntryOfs(EntryOfs)) u_chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // card contents over a hash of sector number and byte index
  function automatic logWriterPkg::byteT sectorByte(input int unsigned addr, input int idx);
    logic [31:0] h;
    h = addr * 32'h9E3779B1 + idx * 32'h85EB;
    case (addr)
      0: begin
        if (idx == 455) return 8'h08;
        if (idx == 454 || idx == 456 || idx == 457) return 8'h00;
        if (idx == 510) return 8'h55;
        if (idx == 511) return badMbr ? 8'h00 : 8'hAA;
      end
      2048: begin
        case (idx)
          13: return 8'd8;
          14: return 8'd32;
          16: return 8'd2;
          36: return 8'd100;
          44: return 8'd2;
          15, 37, 38, 39, 45, 46, 47: return 8'h00;
          default: ;
        endcase
      end
      2281: begin
        if (idx >= EntryOfs && idx < EntryOfs + 11) return FileName[8*(10-(idx-EntryOfs)) +: 8];
        if (idx == EntryOfs + 26) return 8'd5;
        if (idx inside {EntryOfs + 20, EntryOfs + 21, EntryOfs + 27}) return 8'h00;
        if (idx >= EntryOfs + 28 && idx < EntryOfs + 32) return 8'h00;
      end
      default: ;
    endcase
    return h[31:24] ^ h[7:0];
  endfunction

  // --------------------------------------------------
  // card model tasks start on a rising edge
  // --------------------------------------------------
  task automatic serveRead();
    int unsigned addr;
    int gap;
    addr = secAddr;
    for (int i = 0; i < 512; i++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        #1 secRdValid = 1'b0;
        @(posedge clk);
      end
      #1 secRdValid = 1'b1;
      secRdByte = sectorByte(addr, i);
      @(posedge clk);
    end
    #1 secRdValid = 1'b0;
    secRdAck = 1'b1;
    while (secRdReq) @(posedge clk);
    #1 secRdAck = 1'b0;
  endtask

  task automatic serveWrite();
    int gap;
    for (int i = 0; i < 512; i++) begin
      gap = $urandom % 7;
      repeat (gap) begin
        #1 secWrTake = 1'b0;
        @(posedge clk);
      end
      #1 secWrTake = 1'b1;
      @(posedge clk);
    end
    #1 secWrTake = 1'b0;
    secWrAck = 1'b1;
    while (secWrReq) @(posedge clk);
    #1 secWrAck = 1'b0;
    writesDone++;
  endtask

  initial begin
    forever begin
      @(posedge clk);
      if (rstn && secRdReq && !secRdAck) serveRead();
      else if (rstn && secWrReq && !secWrAck) serveWrite();
    end
  end

  // four-phase byte source starting on a rising edge
  task automatic sendBytes(input int n);
    for (int i = 0; i < n; i++) begin
      #1 inByte = 8'($urandom);
      inReq = 1'b1;
      do @(posedge clk); while (!inAck);
      #1 inReq = 1'b0;
      do @(posedge clk); while (inAck);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, %0d errors", cycles, errorCount);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(64312));
    {inReq, secRdAck, secRdValid, secWrAck, secWrTake, rowDone, badMbr, expFull} = '0;
    {inByte, secRdByte} = '0;
    rstn = 1'b0;
    testName = '0;
    expSectors = 0;
    expStatus = '0;
    writesDone = 0;
    cycles = 0;
    rowName[0] = "twoSectors";
    rowBytes[0] = 1024;
    rowBadMbr[0] = 0;
    rowSectors[0] = 2;
    rowStatus[0] = 4'd8;
    rowFull[0] = 0;
    rowName[1] = "fifoFull";
    rowBytes[1] = 3072;
    rowBadMbr[1] = 0;
    rowSectors[1] = 6;
    rowStatus[1] = 4'd8;
    rowFull[1] = 1;
    rowName[2] = "badMbr";
    rowBytes[2] = 512;
    rowBadMbr[2] = 1;
    rowSectors[2] = 0;
    rowStatus[2] = 4'd15;
    rowFull[2] = 0;
    limit = 0;
    for (int r = 0; r < Rows; r++) limit += rowBytes[r] * 8 + 6 * 2000;
    for (int r = 0; r < Rows; r++) begin
      #1 rstn = 1'b0;
      testName = rowName[r];
      badMbr = rowBadMbr[r];
      expSectors = rowSectors[r];
      expStatus = rowStatus[r];
      expFull = rowFull[r];
      writesDone = 0;
      repeat (10) @(posedge clk);
      #1 rstn = 1'b1;
      @(posedge clk);
      sendBytes(rowBytes[r]);
      // row ends once all writes are acked and the FSM settles
      do @(posedge clk);
      while (!(writesDone == 2 * rowSectors[r] && 4'(status) == rowStatus[r] &&
               !secWrReq && !secWrAck));
      repeat (4) @(posedge clk);
      #1 rowDone = 1'b1;
      @(posedge clk);
      #1 rowDone = 1'b0;
    end
    $display("checks done: %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: logWriter.f
+incdir+logic
logic/logWriterPkg.sv
logic/sectorStreamIf.sv
logic/sectorSequencer.sv
logic/sectorByteCounter.sv
logic/bootParser.sv
logic/dirSectorStore.sv
logic/sectorFifo.sv
logic/logWriterTop.sv
tests/logWriterChecker.sv
tests/logWriterTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the logWriter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f logWriter.f --top-module logWriterTb -o logWriterSim
./obj_dir/logWriterSim | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
grep -q "Everything OK" sim.log
echo "simulation passed"
